//--- list.f
+incdir+verilog
verilog/mem_host_pkg.sv
verilog/access_tracker.sv
verilog/trojan5.sv
verilog/mem_array.sv
verilog/mem_ctrl_fsm.sv
verilog/trojan5_memory_host.sv
sim/tb_trojan5_memory_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory host testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 \
        -f list.f \
        --top-module tb_trojan5_memory_host \
        -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench passed" <<< "$sim_out"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- sim/tb_trojan5_memory_host.sv
// Testbench for the trojan5 memory host
// Table-driven requests checked against a model of tracker, trojan and memory

`timescale 1ns/1ps

`include "mem_host_config.svh"

module tb_trojan5_memory_host
    import mem_host_pkg::*;
;

    localparam int ACC_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT = 50;

    logic  clk;
    logic  pon_rst_n_i;
    logic  req_valid_i;
    logic  req_ready_o;
    logic  req_write_i;
    addr_t req_addr_i;
    data_t req_wdata_i;
    logic  rsp_valid_o;
    logic  rsp_error_o;
    data_t rsp_rdata_o;

    // Stimulus table, one entry per request
    logic  tbl_wr[$];
    addr_t tbl_addr[$];
    data_t tbl_data[$];
    int    tbl_gap[$];  // Idle cycles before the request
    logic  tbl_err[$];  // Expected error flag

    // Expected responses in acceptance order
    logic  exp_err_q[$];
    data_t exp_rdata_q[$];
    bit    exp_known_q[$];
    int    acc_cycle_q[$];

    // Reference model state
    logic [31:0] m_lfsr;
    pc_t         m_pc;
    cnt_t        m_cnt;
    data_t       m_mem[0:`MH_MEM_SIZE-1];
    bit          m_written[0:`MH_MEM_SIZE-1];
    bit          m_fired[0:`MH_MEM_SIZE-1];  // Payload not yet read back
    data_t       m_last_rd;
    bit          m_last_known;

    logic [31:0] rng_state;
    int cycle        = 0;
    int err_count    = 0;
    int check_count  = 0;
    int timeouts     = 0;
    int fire_count   = 0;
    int fire_seen    = 0;
    int req_count    = 0;
    int rsp_count    = 0;
    int last_acc     = 0;
    bit have_last    = 0;
    bit aborted      = 0;

    trojan5_memory_host u_dut (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_error_o (rsp_error_o),
        .rsp_rdata_o (rsp_rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_cnt(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], rng_state[0]};
            rng_state = galois_step(rng_state);
        end
        return v;
    endfunction

    task automatic add_entry(input logic wr, input addr_t addr, input data_t data,
                             input int gap, input logic err);
        tbl_wr.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_gap.push_back(gap);
        tbl_err.push_back(err);
    endtask

    task automatic load_directed();
        //        wr    addr     data      gap err
        add_entry(1'b1, 10'h005, 16'h1234, 3, 1'b0);
        add_entry(1'b0, 10'h005, 16'h0000, 2, 1'b0);
        add_entry(1'b1, 10'h2ff, 16'hbeef, 0, 1'b0); // Top legal word
        add_entry(1'b0, 10'h2ff, 16'h0000, 0, 1'b0);
        add_entry(1'b1, 10'h300, 16'hdead, 1, 1'b1); // First illegal word
        add_entry(1'b0, 10'h3ff, 16'h0000, 0, 1'b1);
        add_entry(1'b0, 10'h005, 16'h0000, 0, 1'b0);
        add_entry(1'b1, 10'h010, 16'ha5a5, 0, 1'b0);
        add_entry(1'b1, 10'h011, 16'h5a5a, 0, 1'b0);
        add_entry(1'b1, 10'h012, 16'h0f0f, 0, 1'b0);
        add_entry(1'b0, 10'h010, 16'h0000, 0, 1'b0);
        add_entry(1'b0, 10'h011, 16'h0000, 0, 1'b0);
        add_entry(1'b0, 10'h012, 16'h0000, 4, 1'b0);
    endtask

    // Fill a small window and then run mostly back-to-back random traffic
    task automatic load_random();
        logic [31:0] r;
        addr_t       addr;
        int          gap;
        for (int a = 0; a < 32; a++) begin
            add_entry(1'b1, addr_t'(a), data_t'(rand_bits(16)), 0, 1'b0);
        end
        for (int k = 0; k < 300; k++) begin
            if (rand_bits(4) == 32'd15) begin
                addr = addr_t'(32'h300 + rand_bits(8)); // Out of range
            end else begin
                addr = addr_t'(rand_bits(5));
            end
            r   = rand_bits(1);
            gap = (rand_bits(3) == 32'd0) ? int'(rand_bits(2)) + 1 : 0;
            add_entry(r[0], addr, data_t'(rand_bits(16)), gap,
                      int'(addr) >= `MH_MEM_SIZE);
        end
    endtask

    // Tracker, trojan and memory advanced for one accepted request
    task automatic model_accept(input int idx);
        logic      fb;
        logic      legal;
        prog_dat_t prog_dat;
        pc_t       prog_adr;
        addr_t     addr;
        addr  = tbl_addr[idx];
        legal = int'(addr) < `MH_MEM_SIZE;
        fb     = m_lfsr[31] ^ m_lfsr[23] ^ m_lfsr[17] ^ m_lfsr[9];
        m_lfsr = {m_lfsr[30:0], fb};
        m_pc   = m_pc + pc_t'(addr);
        m_cnt  = m_cnt + cnt_t'(1);
        if (legal && tbl_wr[idx]) begin
            m_mem[addr]     = tbl_data[idx];
            m_written[addr] = 1'b1;
            m_fired[addr]   = 1'b0;
        end else if (legal) begin
            m_last_rd    = m_mem[addr];
            m_last_known = m_written[addr];
            if (m_fired[addr] && m_written[addr]) begin
                fire_seen++; // This read checks a corrupted word
                m_fired[addr] = 1'b0;
            end
        end
        exp_err_q.push_back(tbl_err[idx]);
        exp_rdata_q.push_back(m_last_rd); // Old value held on write or error
        exp_known_q.push_back(m_last_known);
        acc_cycle_q.push_back(cycle);
        prog_dat = m_lfsr[13:0] ^ prog_dat_t'(addr);
        prog_adr = prog_dat[13] ? m_pc + prog_dat[12:0] : m_pc;
        if (legal && m_cnt[1:0] == 2'b01 && prog_adr[2:0] == 3'b101) begin
            m_mem[addr]   = m_mem[addr] ^ data_t'(prog_adr);
            m_fired[addr] = 1'b1;
            fire_count++;
        end
    endtask

    task automatic drive_entry(input int idx);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 0;
        if (tbl_gap[idx] > 0) begin
            req_valid_i <= 1'b0;
            repeat (tbl_gap[idx]) @(posedge clk);
        end
        req_valid_i <= 1'b1;
        req_write_i <= tbl_wr[idx];
        req_addr_i  <= tbl_addr[idx];
        req_wdata_i <= tbl_data[idx];
        while (!accepted && waited < ACC_TIMEOUT) begin
            @(posedge clk);
            waited++;
            if (req_ready_o) accepted = 1;
        end
        if (!accepted) begin
            $display("Timeout: request %0d was never accepted", idx);
            timeouts++;
            aborted = 1;
        end else begin
            if (tbl_gap[idx] == 0 && have_last) begin
                check_cnt("accept_interval", cycle - last_acc, 3);
            end
            last_acc  = cycle;
            have_last = 1;
            req_count++;
            model_accept(idx);
        end
    endtask

    // Response raised by edge E+2 and seen here at edge E+3
    always @(posedge clk) begin : rsp_monitor
        if (pon_rst_n_i && rsp_valid_o) begin
            rsp_count++;
            if (exp_err_q.size() == 0) begin
                $display("Response arrived with no request outstanding");
                err_count++;
            end else begin
                check_flag("rsp_error_o", rsp_error_o, exp_err_q.pop_front());
                check_cnt("rsp_latency", cycle - acc_cycle_q.pop_front(), 3);
                if (exp_known_q.pop_front()) begin
                    check_data("rsp_rdata_o", rsp_rdata_o, exp_rdata_q.pop_front());
                end else begin
                    void'(exp_rdata_q.pop_front());
                end
            end
        end else if (rsp_error_o === 1'b1) begin
            check_flag("rsp_error_o", rsp_error_o, 1'b0); // Error outside a response
        end
    end

    initial begin
        int waited;
        rng_state    = 32'h8030;
        pon_rst_n_i  = 1'b0;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        m_lfsr       = `MH_LFSR_SEED;
        m_pc         = '0;
        m_cnt        = '0;
        m_last_rd    = '0;
        m_last_known = 1'b1;
        for (int a = 0; a < `MH_MEM_SIZE; a++) begin
            m_mem[a]     = '0;
            m_written[a] = 1'b0;
            m_fired[a]   = 1'b0;
        end
        load_directed();
        load_random();

        repeat (10) @(posedge clk);
        pon_rst_n_i <= 1'b1;
        @(posedge clk);
        check_flag("req_ready_o", req_ready_o, 1'b1);
        check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
        check_flag("rsp_error_o", rsp_error_o, 1'b0);

        for (int i = 0; i < tbl_wr.size(); i++) begin
            if (!aborted) drive_entry(i);
        end
        req_valid_i <= 1'b0;

        waited = 0;
        while (rsp_count != req_count && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rsp_count != req_count) begin
            $display("Timeout: responses still outstanding after the last request");
            timeouts++;
        end
        repeat (4) @(posedge clk); // Catch any stray response
        check_cnt("rsp_count", rsp_count, req_count);
        if (fire_count == 0) begin
            $display("No payload firing was seen over the whole run");
            err_count++;
        end
        if (fire_seen == 0) begin
            $display("No read returned a word corrupted by the payload");
            err_count++;
        end

        $display("Checks %0d, errors %0d, timeouts %0d, requests %0d, responses %0d, fires %0d",
                 check_count, err_count, timeouts, req_count, rsp_count, fire_count);
        if (err_count == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/access_tracker.sv
// Access tracker for the memory host
// LFSR, virtual PC and access counter stepped on every accepted request

`timescale 1ns/1ps

`include "mem_host_config.svh"

module access_tracker
    import mem_host_pkg::*;
(
    input  logic      clk,
    input  logic      pon_rst_n_i,
    input  logic      acc_i,       // One-cycle acceptance pulse
    input  addr_t     acc_addr_i,
    output prog_dat_t prog_dat_o,
    output pc_t       pc_o,
    output cnt_t      cnt_o
);

    logic [31:0] lfsr_q;
    logic        lfsr_fb;
    pc_t         pc_q;
    cnt_t        cnt_q;

    // Taps 31, 23, 17, 9
    assign lfsr_fb = lfsr_q[31] ^ lfsr_q[23] ^ lfsr_q[17] ^ lfsr_q[9];

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            lfsr_q <= `MH_LFSR_SEED;
            pc_q   <= '0;
            cnt_q  <= '0;
        end else if (acc_i) begin
            lfsr_q <= {lfsr_q[30:0], lfsr_fb};
            pc_q   <= pc_q + pc_t'(acc_addr_i); // Address walks the PC
            cnt_q  <= cnt_q + cnt_t'(1);
        end
    end

    // Program data mixes the LFSR with the current address
    assign prog_dat_o = lfsr_q[`MH_PROG_WIDTH-1:0] ^ prog_dat_t'(acc_addr_i);

    assign pc_o  = pc_q;
    assign cnt_o = cnt_q;

endmodule

//--- verilog/mem_array.sv
// Word storage for the memory host
// One access per cycle: write, registered read, or XOR of a mask into a word

`timescale 1ns/1ps

`include "mem_host_config.svh"

module mem_array
    import mem_host_pkg::*;
(
    input  logic  clk,
    input  logic  wr_en_i,
    input  logic  rd_en_i,
    input  addr_t addr_i,
    input  data_t wdata_i,
    output data_t rdata_o,
    input  logic  xor_en_i,
    input  data_t xor_mask_i
);

    // Contents undefined until written
    data_t mem_q [0:`MH_MEM_SIZE-1];
    data_t rdata_q;

    // Write has priority over the XOR port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[addr_i] <= wdata_i;
        end else if (xor_en_i) begin
            mem_q[addr_i] <= mem_q[addr_i] ^ xor_mask_i; // Read-modify-XOR
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- verilog/mem_ctrl_fsm.sv
// Memory host request controller
// Accepts and range-checks requests, sequences the array, responds and decides the payload

`timescale 1ns/1ps

`include "mem_host_config.svh"

module mem_ctrl_fsm
    import mem_host_pkg::*;
(
    input  logic  clk,
    input  logic  pon_rst_n_i,
    // Request side
    input  logic  req_valid_i,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  data_t req_wdata_i,
    output logic  req_ready_o,
    // Response side
    output logic  rsp_valid_o,
    output logic  rsp_error_o,
    output data_t rsp_rdata_o,
    // Tracker and trojan
    output logic  acc_o,
    output addr_t acc_addr_o,
    input  cnt_t  cnt_i,
    input  pc_t   prog_adr_i,
    // Array
    output logic  arr_wr_en_o,
    output logic  arr_rd_en_o,
    output addr_t arr_addr_o,
    output data_t arr_wdata_o,
    input  data_t arr_rdata_i,
    output logic  arr_xor_en_o,
    output data_t arr_xor_mask_o
);

    mem_state_e state_q;
    logic       write_q;
    logic       err_q;
    addr_t      addr_q;
    data_t      wdata_q;
    logic       out_of_range;
    logic       trigger;

    assign req_ready_o  = (state_q == IDLE);
    assign acc_o        = req_valid_i && req_ready_o;
    assign out_of_range = (req_addr_i >= addr_t'(`MH_MEM_SIZE));

    // Live address at acceptance, latched one afterwards
    assign acc_addr_o = (state_q == IDLE) ? req_addr_i : addr_q;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= IDLE;
            write_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (acc_o) begin
                        write_q <= req_write_i;
                        err_q   <= out_of_range;
                        state_q <= out_of_range ? ERROR : ACCESS;
                    end
                end
                ACCESS:  state_q <= DONE; // Array access happens here
                ERROR:   state_q <= DONE; // No array access
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request payload latched at acceptance
    always_ff @(posedge clk) begin
        if (acc_o) begin
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
    end

    assign arr_wr_en_o = (state_q == ACCESS) && write_q;
    assign arr_rd_en_o = (state_q == ACCESS) && !write_q;
    assign arr_addr_o  = addr_q;
    assign arr_wdata_o = wdata_q;

    // Payload after the access completes, legal requests only
    assign trigger = (cnt_i[1:0] == `MH_TRIG_CNT) && (prog_adr_i[2:0] == `MH_TRIG_ADR);
    assign arr_xor_en_o   = (state_q == DONE) && !err_q && trigger;
    assign arr_xor_mask_o = data_t'(prog_adr_i);

    // Response pulse follows the DONE cycle
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_error_o <= 1'b0;
            rsp_rdata_o <= '0;
        end else begin
            rsp_valid_o <= (state_q == DONE);
            rsp_error_o <= (state_q == DONE) && err_q;
            if ((state_q == DONE) && !err_q && !write_q) begin
                rsp_rdata_o <= arr_rdata_i; // Pre-payload read value
            end
        end
    end

endmodule

//--- verilog/mem_host_config.svh
// Memory host configuration constants
// Widths, memory depth, tracker seed and payload trigger values

`ifndef MEM_HOST_CONFIG_SVH
`define MEM_HOST_CONFIG_SVH

// Request and storage geometry
`define MH_ADDR_WIDTH 10
`define MH_DATA_WIDTH 16
`define MH_MEM_SIZE   768   // Addresses at or above are errors

// Tracker reset value
`define MH_LFSR_SEED  32'h90008400

// Trojan program side widths
`define MH_PC_WIDTH   13
`define MH_PROG_WIDTH 14

// Payload trigger
`define MH_TRIG_CNT   2'b01 // Low counter bits that arm
`define MH_TRIG_ADR   3'b101 // Low program address bits that fire

`endif

//--- verilog/mem_host_pkg.sv
// Memory host shared types
// Width typedefs and the controller state encoding

`include "mem_host_config.svh"

package mem_host_pkg;

    typedef logic [`MH_ADDR_WIDTH-1:0] addr_t;     // Word address
    typedef logic [`MH_DATA_WIDTH-1:0] data_t;     // Memory word
    typedef logic [`MH_PC_WIDTH-1:0]   pc_t;       // Virtual PC and program address
    typedef logic [`MH_PROG_WIDTH-1:0] prog_dat_t; // Trojan program data
    typedef logic [7:0]                cnt_t;      // Access counter

    // Controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        DONE   = 2'd2,
        ERROR  = 2'd3
    } mem_state_e;

endpackage

//--- verilog/trojan5.sv
// Trojan5 program address generator
// Combinational jump to pc plus data offset when the data top bit is set

`timescale 1ns/1ps

module trojan5
    import mem_host_pkg::*;
(
    input  logic      pon_rst_n_i,
    input  prog_dat_t prog_dat_i,
    input  pc_t       pc_reg_i,
    output pc_t       prog_adr_o
);

    logic jump;
    pc_t  offset;

    assign jump   = prog_dat_i[$bits(prog_dat_t)-1];
    assign offset = prog_dat_i[$bits(pc_t)-1:0]; // Low data bits as jump distance

    always_comb begin
        if (!pon_rst_n_i) begin
            prog_adr_o = '0; // Held at zero in reset
        end else if (jump) begin
            prog_adr_o = pc_reg_i + offset;
        end else begin
            prog_adr_o = pc_reg_i;
        end
    end

endmodule

//--- verilog/trojan5_memory_host.sv
// Trojan5 memory host top level
// Connects the access tracker, trojan, request controller and word array

`timescale 1ns/1ps

module trojan5_memory_host
    import mem_host_pkg::*;
(
    input  logic  clk,
    input  logic  pon_rst_n_i,
    input  logic  req_valid_i,
    output logic  req_ready_o,
    input  logic  req_write_i,
    input  addr_t req_addr_i,
    input  data_t req_wdata_i,
    output logic  rsp_valid_o,
    output logic  rsp_error_o,
    output data_t rsp_rdata_o
);

    logic      acc;
    addr_t     acc_addr;
    prog_dat_t prog_dat;
    pc_t       pc;
    cnt_t      cnt;
    pc_t       prog_adr;
    logic      arr_wr_en;
    logic      arr_rd_en;
    addr_t     arr_addr;
    data_t     arr_wdata;
    data_t     arr_rdata;
    logic      arr_xor_en;
    data_t     arr_xor_mask;

    access_tracker u_tracker (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .acc_i       (acc),
        .acc_addr_i  (acc_addr),
        .prog_dat_o  (prog_dat),
        .pc_o        (pc),
        .cnt_o       (cnt)
    );

    trojan5 u_trojan (
        .pon_rst_n_i (pon_rst_n_i),
        .prog_dat_i  (prog_dat),
        .pc_reg_i    (pc),
        .prog_adr_o  (prog_adr)
    );

    mem_ctrl_fsm u_ctrl (
        .clk            (clk),
        .pon_rst_n_i    (pon_rst_n_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_error_o    (rsp_error_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .acc_o          (acc),
        .acc_addr_o     (acc_addr),
        .cnt_i          (cnt),
        .prog_adr_i     (prog_adr),
        .arr_wr_en_o    (arr_wr_en),
        .arr_rd_en_o    (arr_rd_en),
        .arr_addr_o     (arr_addr),
        .arr_wdata_o    (arr_wdata),
        .arr_rdata_i    (arr_rdata),
        .arr_xor_en_o   (arr_xor_en),
        .arr_xor_mask_o (arr_xor_mask)
    );

    mem_array u_mem (
        .clk        (clk),
        .wr_en_i    (arr_wr_en),
        .rd_en_i    (arr_rd_en),
        .addr_i     (arr_addr),
        .wdata_i    (arr_wdata),
        .rdata_o    (arr_rdata),
        .xor_en_i   (arr_xor_en),
        .xor_mask_i (arr_xor_mask)
    );

endmodule
